// File: source/soc_pkg.sv
package soc_pkg;

    // Data path and memory map
    localparam int xlen = 32;
    localparam int mem_words = 512;
    localparam int mem_index_bits = $clog2(mem_words);

    localparam logic [xlen-1:0] ram_base = 32'h0000_0400;
    localparam logic [xlen-1:0] key_addr = 32'h0000_1000;
    localparam logic [xlen-1:0] uart_addr = 32'h0000_1004;
    localparam logic [xlen-1:0] irq_vector = 32'h0000_0040;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_load_wait
    } core_state_e;

    // One decoded instruction
    typedef struct packed {
        alu_op_e         alu_op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
        logic            use_imm;
        logic            reg_write;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic            is_mret;
    } decoded_t;

endpackage

// File: source/cpu_bus_if.sv
`timescale 1ns/10ps

interface cpu_bus_if;
    import soc_pkg::*;

    logic [xlen-1:0] address;
    logic [xlen-1:0] write_data;
    logic            write_enable;
    logic            read_enable;
    // Valid the cycle after read_enable
    logic [xlen-1:0] read_data;

    modport core (
        output address,
        output write_data,
        output write_enable,
        output read_enable,
        input  read_data
    );

    modport memory (
        input  address,
        input  write_data,
        input  write_enable,
        input  read_enable,
        output read_data
    );

endinterface

// File: source/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  logic [soc_pkg::xlen-1:0] instruction,
    output soc_pkg::decoded_t        decoded
);
    import soc_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;

    assign opcode = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // Sign-extended immediates
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        // Default is a no-operation
        decoded = '0;
        decoded.alu_op = alu_add;
        decoded.rd = instruction[11:7];
        decoded.rs1 = instruction[19:15];
        decoded.rs2 = instruction[24:20];

        case (opcode)
            op_imm: begin
                decoded.imm = imm_i;
                decoded.use_imm = 1'b1;
                decoded.reg_write = 1'b1;
                case (funct3)
                    3'b000: decoded.alu_op = alu_add;
                    3'b100: decoded.alu_op = alu_xor;
                    3'b110: decoded.alu_op = alu_or;
                    3'b111: decoded.alu_op = alu_and;
                    // Shifts and compares are not supported
                    default: decoded.reg_write = 1'b0;
                endcase
            end
            op_reg: begin
                decoded.reg_write = 1'b1;
                if (funct3 == 3'b000 && funct7 == 7'h20) begin
                    decoded.alu_op = alu_sub;
                end else if (funct7 != 7'h00) begin
                    decoded.reg_write = 1'b0;
                end else begin
                    case (funct3)
                        3'b000: decoded.alu_op = alu_add;
                        3'b100: decoded.alu_op = alu_xor;
                        3'b110: decoded.alu_op = alu_or;
                        3'b111: decoded.alu_op = alu_and;
                        default: decoded.reg_write = 1'b0;
                    endcase
                end
            end
            op_load: begin
                // LW only
                if (funct3 == 3'b010) begin
                    decoded.imm = imm_i;
                    decoded.use_imm = 1'b1;
                    decoded.reg_write = 1'b1;
                    decoded.is_load = 1'b1;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    decoded.imm = imm_s;
                    decoded.use_imm = 1'b1;
                    decoded.is_store = 1'b1;
                end
            end
            op_branch: begin
                // BEQ and BNE compare through a subtract
                if (funct3[2:1] == 2'b00) begin
                    decoded.imm = imm_b;
                    decoded.alu_op = alu_sub;
                    decoded.is_branch = 1'b1;
                    decoded.branch_ne = funct3[0];
                end
            end
            op_jal: begin
                decoded.imm = imm_j;
                decoded.reg_write = 1'b1;
                decoded.is_jal = 1'b1;
            end
            op_system: begin
                decoded.is_mret = (instruction == 32'h3020_0073);
            end
            default: decoded.reg_write = 1'b0;
        endcase
    end

endmodule

// File: source/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  soc_pkg::decoded_t        decoded,
    input  logic [soc_pkg::xlen-1:0] pc,
    input  logic [soc_pkg::xlen-1:0] rs1_value,
    input  logic [soc_pkg::xlen-1:0] rs2_value,
    input  logic                     issue,
    output logic [soc_pkg::xlen-1:0] alu_result,
    output logic [soc_pkg::xlen-1:0] next_pc,
    cpu_bus_if.core                  bus
);
    import soc_pkg::*;

    logic [xlen-1:0] operand_b;
    logic            equal;
    logic            taken;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;

    assign operand_b = decoded.use_imm ? decoded.imm : rs2_value;

    always_comb begin
        case (decoded.alu_op)
            alu_add: alu_result = rs1_value + operand_b;
            alu_sub: alu_result = rs1_value - operand_b;
            alu_xor: alu_result = rs1_value ^ operand_b;
            alu_or:  alu_result = rs1_value | operand_b;
            alu_and: alu_result = rs1_value & operand_b;
            default: alu_result = rs1_value + operand_b;
        endcase
    end

    // Branches decode to a subtract, so zero means equal
    assign equal = (alu_result == '0);
    assign taken = decoded.is_branch && (decoded.branch_ne ? !equal : equal);

    assign pc_plus4 = pc + xlen'(4);
    assign pc_target = pc + decoded.imm;
    assign next_pc = (taken || decoded.is_jal) ? pc_target : pc_plus4;

    // Loads and stores add the immediate in the ALU
    assign bus.address = alu_result;
    assign bus.write_data = rs2_value;
    assign bus.read_enable = issue && decoded.is_load;
    assign bus.write_enable = issue && decoded.is_store;

endmodule

// File: source/rv_result.sv
`timescale 1ns/10ps

module rv_result (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  soc_pkg::decoded_t        decoded,
    input  logic [soc_pkg::xlen-1:0] alu_result,
    input  logic [soc_pkg::xlen-1:0] load_data,
    input  logic [soc_pkg::xlen-1:0] pc,
    input  soc_pkg::core_state_e     state,
    output logic [soc_pkg::xlen-1:0] rs1_value,
    output logic [soc_pkg::xlen-1:0] rs2_value
);
    import soc_pkg::*;

    logic [xlen-1:0] regs [0:31];
    logic [xlen-1:0] wb_value;
    logic            wb_state_ok;
    logic            wb_enable;

    // x0 is never written, so it reads zero
    assign rs1_value = regs[decoded.rs1];
    assign rs2_value = regs[decoded.rs2];

    always_comb begin
        if (state == st_load_wait) begin
            wb_value = load_data;
        end else if (decoded.is_jal) begin
            // Link address
            wb_value = pc + xlen'(4);
        end else begin
            wb_value = alu_result;
        end
    end

    // Loads write one state later than everything else
    assign wb_state_ok = decoded.is_load ? (state == st_load_wait) : (state == st_execute);
    assign wb_enable = decoded.reg_write && (decoded.rd != 5'd0) && wb_state_ok;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable) begin
            regs[decoded.rd] <= wb_value;
        end
    end

endmodule

// File: source/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    output logic [soc_pkg::xlen-1:0] fetch_address,
    input  logic [soc_pkg::xlen-1:0] instruction,
    input  logic                     irq_pending,
    output logic                     irq_ack,
    cpu_bus_if.core                  bus
);
    import soc_pkg::*;

    core_state_e     state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] mepc;
    logic            irq_enable;
    decoded_t        decoded_w;
    decoded_t        decoded_q;
    decoded_t        decoded_cur;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] next_pc;

    assign fetch_address = pc;

    // Interrupt entry only between instructions and never nested
    assign irq_ack = (state == st_fetch) && irq_pending && irq_enable;

    // In load_wait the fetch port already shows the next instruction
    assign decoded_cur = (state == st_load_wait) ? decoded_q : decoded_w;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= st_fetch;
            pc <= reset_pc;
            mepc <= reset_pc;
            irq_enable <= 1'b1;
        end else begin
            case (state)
                st_fetch: begin
                    if (irq_ack) begin
                        mepc <= pc;
                        pc <= irq_vector;
                        irq_enable <= 1'b0;
                    end else begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (decoded_w.is_mret) begin
                        pc <= mepc;
                        irq_enable <= 1'b1;
                    end else begin
                        pc <= next_pc;
                    end
                    state <= decoded_w.is_load ? st_load_wait : st_fetch;
                end
                st_load_wait: state <= st_fetch;
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == st_execute) begin
            decoded_q <= decoded_w;
        end
    end

    rv_decode decode (
        .instruction (instruction),
        .decoded     (decoded_w)
    );

    rv_execute execute (
        .decoded    (decoded_cur),
        .pc         (pc),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .issue      (state == st_execute),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .bus        (bus)
    );

    rv_result result (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .decoded    (decoded_cur),
        .alu_result (alu_result),
        .load_data  (bus.read_data),
        .pc         (pc),
        .state      (state),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value)
    );

endmodule

// File: source/cpu_on_board.sv
`timescale 1ns/10ps

module cpu_on_board (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] key_code,
    input  logic       key_strobe,
    output logic [7:0] uart_data,
    output logic       uart_strobe,
    output logic       irq_led,
    output logic [5:0] pc_leds
);
    import soc_pkg::*;

    logic [xlen-1:0]           mem [0:mem_words-1];
    logic [xlen-1:0]           fetch_address;
    logic [xlen-1:0]           fetch_word;
    logic [xlen-1:0]           instruction;
    logic [mem_index_bits-1:0] fetch_index;
    logic [mem_index_bits-1:0] bus_index;
    logic                      key_sel;
    logic                      uart_sel;
    logic                      mem_sel;
    logic                      mem_writable;
    logic                      irq_pending;
    logic                      irq_ack;
    logic                      key_accept;
    logic [7:0]                key_latch;

    cpu_bus_if bus ();

    rv_core core (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .fetch_address (fetch_address),
        .instruction   (instruction),
        .irq_pending   (irq_pending),
        .irq_ack       (irq_ack),
        .bus           (bus)
    );

    initial begin
        $readmemh("rom.mem", mem);
    end

    // Registered fetch port, words are stored byte-swapped
    assign fetch_index = fetch_address[mem_index_bits+1:2];
    always_ff @(posedge CLOCK_50) begin
        fetch_word <= mem[fetch_index];
    end
    assign instruction = {fetch_word[7:0], fetch_word[15:8],
                          fetch_word[23:16], fetch_word[31:24]};

    // Address decode
    assign key_sel = (bus.address == key_addr);
    assign uart_sel = (bus.address == uart_addr);
    assign mem_sel = (bus.address < xlen'(mem_words * 4));
    // Program area below ram_base is read-only
    assign mem_writable = mem_sel && (bus.address >= ram_base);
    assign bus_index = bus.address[mem_index_bits+1:2];

    always_ff @(posedge CLOCK_50) begin
        if (bus.write_enable && mem_writable) begin
            mem[bus_index] <= bus.write_data;
        end
        if (bus.read_enable) begin
            if (key_sel) begin
                bus.read_data <= {24'd0, key_latch};
            end else if (mem_sel) begin
                bus.read_data <= mem[bus_index];
            end else begin
                bus.read_data <= '0;
            end
        end
    end

    // UART byte and strobe one cycle after the store
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_strobe <= 1'b0;
        end else begin
            uart_strobe <= bus.write_enable && uart_sel;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus.write_enable && uart_sel) begin
            uart_data <= bus.write_data[7:0];
        end
    end

    // Single-source interrupt controller
    assign key_accept = key_strobe && (key_code != 8'd0) && !irq_pending;

    always_ff @(posedge CLOCK_50) begin
        if (key_accept) begin
            key_latch <= key_code;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_pending <= 1'b0;
        end else if (irq_ack) begin
            irq_pending <= 1'b0;
        end else if (key_accept) begin
            irq_pending <= 1'b1;
        end
    end

    assign irq_led = irq_pending;
    // PC word index
    assign pc_leds = fetch_address[7:2];

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period = 8,
    parameter int reset_cycles = 16
) (
    output logic CLOCK_50,
    output logic KEY0
);

    initial begin
        CLOCK_50 = 1'b0;
        forever #(period / 2) CLOCK_50 = ~CLOCK_50;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        KEY0 = 1'b0;
        repeat (reset_cycles) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

// File: verification/cpu_on_board_assertions.sv
`timescale 1ns/10ps

module cpu_on_board_assertions (
    input logic CLOCK_50,
    input logic KEY0,
    input logic uart_strobe,
    input logic irq_led,
    input logic irq_ack,
    input logic read_enable,
    input logic write_enable
);

    // Number of failed assertions so far
    int failures = 0;

    // A UART store gives a single-cycle pulse
    uart_strobe_single: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) uart_strobe |=> !uart_strobe
    ) else begin
        failures++;
        $error("uart_strobe high on two consecutive cycles");
    end

    bus_one_request: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) !(read_enable && write_enable)
    ) else begin
        failures++;
        $error("bus read and write enables high together");
    end

    // Pending clears only on the core's acknowledge
    irq_led_falls_on_ack: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) $fell(irq_led) |-> $past(irq_ack)
    ) else begin
        failures++;
        $error("irq_led fell without a preceding irq_ack");
    end

endmodule

// File: verification/tb_cpu_on_board.sv
`timescale 1ns/10ps

module tb_cpu_on_board;

    localparam int clock_period = 8;
    localparam int reset_cycles = 16;
    localparam int idle_cycles = 200;
    localparam int key_gap = 100;
    localparam int byte_timeout = 60;
    localparam int random_keys = 12;
    // Random keys plus the zero key and the double strobe
    localparam int total_keys = random_keys + 2;
    localparam int watchdog_cycles = reset_cycles + idle_cycles + (total_keys + 1) * key_gap;
    // PC word index in the fetch that follows each UART store of the handler
    localparam logic [5:0] echo_next_index = 6'h16;
    localparam logic [5:0] sum_next_index = 6'h1b;

    logic       CLOCK_50;
    logic       KEY0;
    logic [7:0] key_code;
    logic       key_strobe;
    logic [7:0] uart_data;
    logic       uart_strobe;
    logic       irq_led;
    logic [5:0] pc_leds;

    // {echo, sum} for every accepted key, oldest first
    logic [15:0] expected_pairs [$];
    logic        sum_pending = 1'b0;
    logic [7:0]  model_sum;
    logic [31:0] random_state;
    string       test_name = "reset";

    tb_clock_gen #(.period(clock_period), .reset_cycles(reset_cycles)) clock_gen (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    cpu_on_board uut (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_code    (key_code),
        .key_strobe  (key_strobe),
        .uart_data   (uart_data),
        .uart_strobe (uart_strobe),
        .irq_led     (irq_led),
        .pc_leds     (pc_leds)
    );

    bind cpu_on_board cpu_on_board_assertions assertion_checks (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .uart_strobe  (uart_strobe),
        .irq_led      (irq_led),
        .irq_ack      (irq_ack),
        .read_enable  (bus.read_enable),
        .write_enable (bus.write_enable)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Zero is kept for the ignored-key case
    function automatic logic [7:0] key_from(input logic [31:0] value);
        return (value[7:0] == 8'd0) ? 8'h5a : value[7:0];
    endfunction

    // Echo flips the case bit, the sum wraps at eight bits
    function automatic logic [15:0] uart_bytes_for_key(input logic [7:0] code,
                                                       input logic [7:0] sum_before);
        logic [7:0] echo;
        logic [7:0] sum_after;
        echo = code ^ 8'h20;
        sum_after = sum_before + code;
        return {echo, sum_after};
    endfunction

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_echo(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s echo byte expected %02h actual %02h", name, expected, actual);
            fail_now("echo byte mismatch");
        end
    endtask

    task automatic compare_sum(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s sum byte expected %02h actual %02h", name, expected, actual);
            fail_now("sum byte mismatch");
        end
    endtask

    task automatic expect_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            fail_now("status output mismatch");
        end
    endtask

    task automatic expect_pc_leds(input string name, input logic [5:0] expected,
                                  input logic [5:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s pc_leds expected %02h actual %02h", name, expected, actual);
            fail_now("pc_leds mismatch");
        end
    endtask

    // Strobe on one edge, or on two edges with a second code
    // irq_led is sampled in the cycle after the first strobe edge
    task automatic send_key(input logic [7:0] code, input bit repeat_strobe,
                            input logic [7:0] second_code, output logic led_after);
        @(posedge CLOCK_50);
        key_code <= code;
        key_strobe <= 1'b1;
        @(posedge CLOCK_50);
        if (repeat_strobe) begin
            key_code <= second_code;
        end else begin
            key_strobe <= 1'b0;
        end
        @(negedge CLOCK_50);
        led_after = irq_led;
        if (repeat_strobe) begin
            @(posedge CLOCK_50);
            key_strobe <= 1'b0;
        end
    endtask

    // Wait for the handler's bytes, then idle out the rest of the gap
    task automatic finish_key_gap();
        int waited;
        waited = 0;
        while (expected_pairs.size() != 0 && waited < byte_timeout) begin
            @(posedge CLOCK_50);
            waited++;
        end
        if (expected_pairs.size() != 0) begin
            fail_now($sformatf("UART bytes missing after %0d cycles in %s",
                               byte_timeout, test_name));
        end else begin
            repeat (key_gap - waited) @(posedge CLOCK_50);
        end
    endtask

    task automatic run_key(input logic [7:0] code, input bit doubled,
                           input logic [7:0] ignored_code);
        logic [15:0] pair;
        logic        led;
        pair = uart_bytes_for_key(code, model_sum);
        expected_pairs.push_back(pair);
        model_sum = pair[7:0];
        send_key(code, doubled, ignored_code, led);
        expect_level({test_name, " irq_led after strobe"}, 1'b1, led);
        finish_key_gap();
    endtask

    // An echo byte is always followed by its sum byte
    always @(negedge CLOCK_50) begin
        if (KEY0 && uart_strobe) begin
            if (expected_pairs.size() == 0) begin
                fail_now($sformatf("unexpected UART byte %02h in %s", uart_data, test_name));
            end else if (!sum_pending) begin
                expect_level({test_name, " irq_led at echo byte"}, 1'b0, irq_led);
                compare_echo(test_name, expected_pairs[0][15:8], uart_data);
                expect_pc_leds({test_name, " echo byte"}, echo_next_index, pc_leds);
                sum_pending = 1'b1;
            end else begin
                compare_sum(test_name, expected_pairs[0][7:0], uart_data);
                expect_pc_leds({test_name, " sum byte"}, sum_next_index, pc_leds);
                void'(expected_pairs.pop_front());
                sum_pending = 1'b0;
            end
        end
    end

    always @(negedge CLOCK_50) begin
        if (uut.assertion_checks.failures != 0) begin
            fail_now("a bound assertion on the board top failed");
        end
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge CLOCK_50);
        fail_now("watchdog expired before the tests completed");
    end

    initial begin
        logic [7:0] code;
        logic [7:0] extra;
        logic       led;
        key_code = 8'd0;
        key_strobe = 1'b0;
        model_sum = 8'd0;
        random_state = 32'h21ff;

        @(posedge KEY0);
        @(negedge CLOCK_50);
        expect_level("reset uart_strobe", 1'b0, uart_strobe);
        expect_level("reset irq_led", 1'b0, irq_led);
        expect_pc_leds("reset", 6'd0, pc_leds);

        test_name = "idle";
        repeat (idle_cycles) @(posedge CLOCK_50);
        expect_pc_leds("idle", 6'd0, pc_leds);

        for (int k = 0; k < random_keys; k++) begin
            if (k == 4) begin
                test_name = "zero key";
                send_key(8'd0, 1'b0, 8'd0, led);
                expect_level("zero key irq_led", 1'b0, led);
                finish_key_gap();
            end
            random_state = xorshift32(random_state);
            code = key_from(random_state);
            if (k == 8) begin
                random_state = xorshift32(random_state);
                extra = key_from(random_state);
                test_name = "double strobe";
                run_key(code, 1'b1, extra);
            end else begin
                test_name = $sformatf("random key %0d", k);
                run_key(code, 1'b0, 8'd0);
            end
        end

        test_name = "end";
        if (expected_pairs.size() == 0 && uut.assertion_checks.failures == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_now("UART bytes still outstanding or an assertion failed at the end");
        end
    end

endmodule

// File: cpu_on_board.f
source/soc_pkg.sv
source/cpu_bus_if.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
source/cpu_on_board.sv
verification/tb_clock_gen.sv
verification/cpu_on_board_assertions.sv
verification/tb_cpu_on_board.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+100
TOP       := tb_cpu_on_board
RTL_TOP   := cpu_on_board
FILE_LIST := cpu_on_board.f
OBJ_DIR   := obj_dir
PASS_TEXT := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@output="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

// File: rom.mem
// One 32-bit word per line, instructions byte-swapped (first byte in memory is leftmost)
// @ lines give the word address; the data word at 0x400 is stored as is
@000
6F000000 // 0x000 jal  x0, 0         idle loop
@010
13010040 // 0x040 addi x2, x0, 0x400  ram_base
B3012100 // 0x044 add  x3, x2, x2
B3813100 // 0x048 add  x3, x3, x3     key_addr
83A00100 // 0x04c lw   x1, 0(x3)      key code
13C20002 // 0x050 xori x4, x1, 0x20   case flip
23A24100 // 0x054 sw   x4, 4(x3)      echo to UART
83220100 // 0x058 lw   x5, 0(x2)      running sum
B3821200 // 0x05c add  x5, x5, x1
93F2F20F // 0x060 andi x5, x5, 0xff
23205100 // 0x064 sw   x5, 0(x2)
23A25100 // 0x068 sw   x5, 4(x3)      sum to UART
73002030 // 0x06c mret
@100
00000000 // 0x400 running sum starts at zero
